// File: dv/i2c_checker.sv
`timescale 1ns/1ps

module i2c_checker #(
    parameter logic [7:0] SENSOR_REG = 8'h10
) (
    input  logic                clk,
    input  logic                rst,
    input  i2c_pkg::cfg_write_t cfg,
    input  logic                cfg_valid,
    input  logic                cfg_ready,
    input  logic                exp_nack,
    input  logic                cfg_done_valid,
    input  logic                cfg_done_nack,
    input  i2c_pkg::sample_t    sample,
    input  logic                sample_valid,
    input  logic                scl,
    input  logic                sda_drive_low,
    input  logic [7:0]          regs [256],
    output int                  done_count,
    output int                  sample_count,
    output int                  pass_count,
    output int                  fail_count
);

    logic [7:0]          exp_mem [256];
    i2c_pkg::cfg_write_t pend;
    logic                pend_nack;
    logic                have_pend;
    logic                reset_checked;
    int                  n_done;
    int                  n_sample;
    int                  n_pass;
    int                  n_fail;

    assign done_count   = n_done;
    assign sample_count = n_sample;
    assign pass_count   = n_pass;
    assign fail_count   = n_fail;

    function automatic bit check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("[FAIL] t=%0t %s expected %0b got %0b", $time, name, exp, act);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic bit check_word(string name, logic [15:0] exp, logic [15:0] act);
        if (exp !== act) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic bit memory_matches();
        for (int i = 0; i < 256; i++) begin
            if (regs[i] !== exp_mem[i]) begin
                $display("[FAIL] t=%0t target_mem[%h] expected %h got %h",
                         $time, i[7:0], exp_mem[i], regs[i]);
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic record(string what, bit ok);
        if (ok) begin
            n_pass = n_pass + 1;
            $display("%s: ok", what);
        end else begin
            n_fail = n_fail + 1;
            $display("%s: failed", what);
        end
    endtask

    initial begin
        bit ok;
        for (int i = 0; i < 256; i++) begin
            exp_mem[i] = 8'(i * 37) ^ 8'h5c;
        end
        have_pend = 1'b0;
        reset_checked = 1'b0;
        n_done = 0;
        n_sample = 0;
        n_pass = 0;
        n_fail = 0;
        forever begin
            @(negedge clk);
            if (!rst && !reset_checked) begin
                reset_checked = 1'b1;
                ok = check_bit("scl", 1'b1, scl);
                ok = check_bit("sda_drive_low", 1'b0, sda_drive_low) && ok;
                ok = check_bit("cfg_done_valid", 1'b0, cfg_done_valid) && ok;
                ok = check_bit("sample_valid", 1'b0, sample_valid) && ok;
                ok = check_bit("cfg_ready", 1'b1, cfg_ready) && ok;
                record("reset state", ok);
            end
            // a done pulse and the next accept can share one cycle
            if (!rst && cfg_done_valid) begin
                n_done = n_done + 1;
                if (!have_pend) begin
                    $display("t=%0t done pulse with no cfg write outstanding", $time);
                    record("unexpected done", 1'b0);
                end else begin
                    have_pend = 1'b0;
                    if (!pend_nack) begin
                        exp_mem[pend.reg_addr] = pend.value;
                    end
                    ok = check_bit("cfg_done_nack", pend_nack, cfg_done_nack);
                    ok = memory_matches() && ok;
                    record($sformatf("cfg write %0d dev %h reg %h", n_done,
                                     pend.dev_addr, pend.reg_addr), ok);
                end
            end
            if (!rst && cfg_valid && cfg_ready) begin
                pend = cfg;
                pend_nack = exp_nack;
                have_pend = 1'b1;
            end
            if (!rst && sample_valid) begin
                n_sample = n_sample + 1;
                ok = check_bit("sample.nack", 1'b0, sample.nack);
                ok = check_word("sample.reg_addr", {8'h00, SENSOR_REG},
                                {8'h00, sample.reg_addr}) && ok;
                ok = check_word("sample.data", {exp_mem[SENSOR_REG], exp_mem[SENSOR_REG + 8'd1]},
                                sample.data) && ok;
                record($sformatf("sample %0d data %h", n_sample, sample.data), ok);
            end
        end
    end

endmodule

// File: dv/i2c_target_model.sv
`timescale 1ns/1ps

module i2c_target_model #(
    parameter logic [6:0] ADDR = 7'h48
) (
    input  logic       scl,
    input  logic       sda,
    output logic       sda_drive_low,
    output logic [7:0] regs [256]
);

    typedef enum int {
        T_IDLE,
        T_ADDR,
        T_WR,
        T_RD,
        T_ACK_OUT,
        T_ACK_IN
    } phase_t;

    phase_t     phase;
    phase_t     next_phase;
    logic       scl_q;
    logic       sda_q;
    logic [7:0] shreg;
    logic [7:0] tx;
    logic [7:0] ptr;
    logic       ptr_set;
    logic       mack;
    int         bit_cnt;

    // put the next register on the bus, msb first
    task automatic load_tx_byte();
        tx = regs[ptr];
        ptr = ptr + 8'd1;
        sda_drive_low = ~tx[7];
    endtask

    task automatic sample_bit();
        case (phase)
            T_ADDR, T_WR: begin
                shreg = {shreg[6:0], sda};
                bit_cnt = bit_cnt + 1;
            end
            T_RD: bit_cnt = bit_cnt + 1;
            T_ACK_IN: mack = sda;
            default: ;
        endcase
    endtask

    task automatic advance_on_fall();
        case (phase)
            T_ADDR: begin
                if (bit_cnt == 8) begin
                    if (shreg[7:1] == ADDR) begin
                        sda_drive_low = 1'b1;
                        next_phase = shreg[0] ? T_RD : T_WR;
                        ptr_set = 1'b0;
                        phase = T_ACK_OUT;
                    end else begin
                        phase = T_IDLE;
                    end
                end
            end
            T_WR: begin
                if (bit_cnt == 8) begin
                    // first written byte is the register pointer
                    if (!ptr_set) begin
                        ptr = shreg;
                        ptr_set = 1'b1;
                    end else begin
                        regs[ptr] = shreg;
                        ptr = ptr + 8'd1;
                    end
                    sda_drive_low = 1'b1;
                    next_phase = T_WR;
                    phase = T_ACK_OUT;
                end
            end
            T_ACK_OUT: begin
                sda_drive_low = 1'b0;
                bit_cnt = 0;
                if (next_phase == T_RD) begin
                    load_tx_byte();
                end
                phase = next_phase;
            end
            T_RD: begin
                if (bit_cnt == 8) begin
                    sda_drive_low = 1'b0;
                    phase = T_ACK_IN;
                end else begin
                    sda_drive_low = ~tx[7-bit_cnt];
                end
            end
            T_ACK_IN: begin
                if (!mack) begin
                    bit_cnt = 0;
                    load_tx_byte();
                    phase = T_RD;
                end else begin
                    phase = T_IDLE;
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            regs[i] = 8'(i * 37) ^ 8'h5c;
        end
        sda_drive_low = 1'b0;
        phase = T_IDLE;
        next_phase = T_IDLE;
        scl_q = 1'b1;
        sda_q = 1'b1;
        ptr = 8'h00;
        ptr_set = 1'b0;
        mack = 1'b1;
        bit_cnt = 0;
        forever begin
            @(scl or sda);
            if (scl_q && scl && sda_q && !sda) begin
                // start condition
                phase = T_ADDR;
                bit_cnt = 0;
                sda_drive_low = 1'b0;
            end else if (scl_q && scl && !sda_q && sda) begin
                phase = T_IDLE;
                sda_drive_low = 1'b0;
            end else if (!scl_q && scl) begin
                sample_bit();
            end else if (scl_q && !scl) begin
                advance_on_fall();
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

// File: dv/tb_i2c_subsystem.sv
`timescale 1ns/1ps

module tb_i2c_subsystem;

    localparam int         CLK_DIV       = 4;
    localparam int         POLL_INTERVAL = 4000;
    localparam logic [7:0] SENSOR_REG    = 8'h10;
    localparam int         NUM_TESTS     = 8;
    localparam int         MIN_SAMPLES   = 2;
    // start, address and data bits with acks, stop, plus handshake slack
    localparam int WORST_XFER = CLK_DIV * (3 + 27 * (i2c_pkg::MAX_BYTES + 1) + 4) + 8;
    localparam longint LIMIT_NS =
        longint'(NUM_TESTS * WORST_XFER + 3 * POLL_INTERVAL) * 100;

    typedef struct packed {
        logic [15:0]         at_cycle;
        i2c_pkg::cfg_write_t cfg;
        logic                exp_nack;
    } stim_t;

    logic                clk;
    logic                rst;
    i2c_pkg::cfg_write_t cfg;
    logic                cfg_valid;
    logic                cfg_ready;
    logic                exp_nack;
    logic                cfg_done_valid;
    logic                cfg_done_nack;
    i2c_pkg::sample_t    sample;
    logic                sample_valid;
    logic                scl;
    logic                dut_sda_low;
    logic                tgt_sda_low;
    wire                 sda;
    logic [7:0]          regs [256];
    stim_t               stim [NUM_TESTS];
    int                  cyc;
    int                  done_count;
    int                  sample_count;
    int                  pass_count;
    int                  fail_count;

    // open-drain bus with pull-up
    assign sda = !(dut_sda_low || tgt_sda_low);

    i2c_subsystem #(
        .CLK_DIV       (CLK_DIV),
        .POLL_INTERVAL (POLL_INTERVAL),
        .SENSOR_ADDR   (7'h48),
        .SENSOR_REG    (SENSOR_REG)
    ) i_i2c_subsystem (
        .clk            (clk),
        .rst            (rst),
        .cfg            (cfg),
        .cfg_valid      (cfg_valid),
        .cfg_ready      (cfg_ready),
        .cfg_done_valid (cfg_done_valid),
        .cfg_done_nack  (cfg_done_nack),
        .sample         (sample),
        .sample_valid   (sample_valid),
        .scl            (scl),
        .sda_drive_low  (dut_sda_low),
        .sda_in         (sda)
    );

    i2c_target_model #(.ADDR(7'h48)) i_target (
        .scl           (scl),
        .sda           (sda),
        .sda_drive_low (tgt_sda_low),
        .regs          (regs)
    );

    i2c_checker #(.SENSOR_REG(SENSOR_REG)) i_checker (
        .clk            (clk),
        .rst            (rst),
        .cfg            (cfg),
        .cfg_valid      (cfg_valid),
        .cfg_ready      (cfg_ready),
        .exp_nack       (exp_nack),
        .cfg_done_valid (cfg_done_valid),
        .cfg_done_nack  (cfg_done_nack),
        .sample         (sample),
        .sample_valid   (sample_valid),
        .scl            (scl),
        .sda_drive_low  (dut_sda_low),
        .regs           (regs),
        .done_count     (done_count),
        .sample_count   (sample_count),
        .pass_count     (pass_count),
        .fail_count     (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    initial begin
        #(LIMIT_NS);
        $display("timeout: transfers did not complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        // at_cycle 0 means right after the previous write
        stim[0] = '{16'd10, '{7'h48, 8'h20, 8'h3c}, 1'b0};
        stim[1] = '{16'd0, '{7'h48, 8'h10, 8'ha1}, 1'b0};
        stim[2] = '{16'd0, '{7'h21, 8'h05, 8'h77}, 1'b1};
        // lands while the first poll holds the bus
        stim[3] = '{16'd4100, '{7'h33, 8'h10, 8'hee}, 1'b1};
        stim[4] = '{16'd0, '{7'h48, 8'h11, 8'h5e}, 1'b0};
        stim[5] = '{16'd0, '{7'h48, 8'h40, 8'h99}, 1'b0};
        stim[6] = '{16'd0, '{7'h48, 8'h41, 8'h12}, 1'b0};
        stim[7] = '{16'd0, '{7'h48, 8'h10, 8'hc3}, 1'b0};

        rst = 1'b1;
        cfg = '0;
        cfg_valid = 1'b0;
        exp_nack = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            @(posedge clk);
            while (cyc < int'(stim[i].at_cycle)) begin
                @(posedge clk);
            end
            cfg <= stim[i].cfg;
            exp_nack <= stim[i].exp_nack;
            cfg_valid <= 1'b1;
            do begin
                @(posedge clk);
            end while (!cfg_ready);
            cfg_valid <= 1'b0;
        end

        wait (done_count == NUM_TESTS && sample_count >= MIN_SAMPLES);
        repeat (2) @(posedge clk);
        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_i2c_subsystem \
    -f vlog.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
grep -q "Simulation finished: PASS" sim.log

// File: source/cfg_writer.sv
`timescale 1ns/1ps

module cfg_writer (
    input  logic                clk,
    input  logic                rst,
    input  i2c_pkg::cfg_write_t cfg,
    input  logic                cfg_valid,
    output logic                cfg_ready,
    output logic                done_valid,
    output logic                done_nack,
    output i2c_pkg::i2c_req_t   req,
    output logic                req_valid,
    input  logic                req_ready,
    input  i2c_pkg::i2c_resp_t  resp,
    input  logic                resp_valid,
    output logic                resp_ready
);

    localparam int PAD = (i2c_pkg::MAX_BYTES - 2) * 8;

    typedef enum logic [1:0] {
        CW_IDLE,
        CW_REQ,
        CW_WAIT
    } state_t;

    state_t              state;
    i2c_pkg::cfg_write_t cfg_q;

    assign cfg_ready  = (state == CW_IDLE);
    assign req_valid  = (state == CW_REQ);
    assign resp_ready = (state == CW_WAIT);

    // register pointer first, then the value
    assign req.dev_addr = cfg_q.dev_addr;
    assign req.read     = 1'b0;
    assign req.nbytes   = 3'd2;
    assign req.wdata    = {cfg_q.reg_addr, cfg_q.value, {PAD{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= CW_IDLE;
            done_valid <= 1'b0;
        end else begin
            done_valid <= 1'b0;
            case (state)
                CW_IDLE: begin
                    if (cfg_valid) begin
                        cfg_q <= cfg;
                        state <= CW_REQ;
                    end
                end
                CW_REQ: begin
                    if (req_ready) begin
                        state <= CW_WAIT;
                    end
                end
                default: begin
                    if (resp_valid) begin
                        done_valid <= 1'b1;
                        done_nack  <= resp.nack;
                        state      <= CW_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: source/i2c_arbiter.sv
`timescale 1ns/1ps

module i2c_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  i2c_pkg::i2c_req_t  cfg_req,
    input  logic               cfg_req_valid,
    output logic               cfg_req_ready,
    output i2c_pkg::i2c_resp_t cfg_resp,
    output logic               cfg_resp_valid,
    input  logic               cfg_resp_ready,
    input  i2c_pkg::i2c_req_t  poll_req,
    input  logic               poll_req_valid,
    output logic               poll_req_ready,
    output i2c_pkg::i2c_resp_t poll_resp,
    output logic               poll_resp_valid,
    input  logic               poll_resp_ready,
    output i2c_pkg::i2c_req_t  eng_req,
    output logic               eng_req_valid,
    input  logic               eng_req_ready,
    input  i2c_pkg::i2c_resp_t eng_resp,
    input  logic               eng_resp_valid,
    output logic               eng_resp_ready
);

    // grant keeps the last served client once unlocked
    i2c_pkg::client_idx_t grant;
    i2c_pkg::client_idx_t sel;
    logic                 locked;

    always_comb begin
        if (locked) begin
            sel = grant;
        end else if (cfg_req_valid && poll_req_valid) begin
            sel = (grant == i2c_pkg::CLIENT_CFG) ? i2c_pkg::CLIENT_POLL : i2c_pkg::CLIENT_CFG;
        end else if (poll_req_valid) begin
            sel = i2c_pkg::CLIENT_POLL;
        end else begin
            sel = i2c_pkg::CLIENT_CFG;
        end
    end

    assign eng_req        = (sel == i2c_pkg::CLIENT_POLL) ? poll_req : cfg_req;
    assign eng_req_valid  = !locked && (cfg_req_valid || poll_req_valid);
    assign cfg_req_ready  = !locked && (sel == i2c_pkg::CLIENT_CFG) && eng_req_ready;
    assign poll_req_ready = !locked && (sel == i2c_pkg::CLIENT_POLL) && eng_req_ready;

    assign cfg_resp        = eng_resp;
    assign poll_resp       = eng_resp;
    assign cfg_resp_valid  = locked && (grant == i2c_pkg::CLIENT_CFG) && eng_resp_valid;
    assign poll_resp_valid = locked && (grant == i2c_pkg::CLIENT_POLL) && eng_resp_valid;
    assign eng_resp_ready  = locked && ((grant == i2c_pkg::CLIENT_POLL) ? poll_resp_ready
                                                                       : cfg_resp_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            grant  <= i2c_pkg::CLIENT_POLL;
        end else if (eng_req_valid && eng_req_ready) begin
            locked <= 1'b1;
            grant  <= sel;
        end else if (eng_resp_valid && eng_resp_ready) begin
            locked <= 1'b0;
        end
    end

endmodule

// File: source/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine #(
    parameter int CLK_DIV = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  i2c_pkg::i2c_req_t  req,
    input  logic               req_valid,
    output logic               req_ready,
    output i2c_pkg::i2c_resp_t resp,
    output logic               resp_valid,
    input  logic               resp_ready,
    output logic               scl,
    output logic               sda_drive_low,
    input  logic               sda_in
);

    localparam int WBITS = i2c_pkg::MAX_BYTES * 8;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_SHIFT,
        ST_ACK,
        ST_STOP,
        ST_RESP
    } state_t;

    state_t            state;
    logic [1:0]        step;
    logic [15:0]       div_cnt;
    logic              tick;
    i2c_pkg::i2c_req_t cur;
    logic [7:0]        shreg;
    logic [2:0]        bit_cnt;
    logic [2:0]        byte_cnt;
    logic              addr_phase;
    logic              ack_bit;
    logic              rx_data;
    logic              last_byte;

    assign tick       = (div_cnt == '0);
    assign rx_data    = cur.read && !addr_phase;
    assign last_byte  = (byte_cnt + 3'd1 == cur.nbytes);
    assign req_ready  = (state == ST_IDLE);
    assign resp_valid = (state == ST_RESP);

    // step divider, realigned on every accepted request
    always_ff @(posedge clk) begin
        if (rst || (req_valid && req_ready) || tick) begin
            div_cnt <= 16'(CLK_DIV - 1);
        end else begin
            div_cnt <= div_cnt - 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            step          <= 2'd0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end else if (state == ST_IDLE) begin
            if (req_valid) begin
                cur        <= req;
                resp.rdata <= '0;
                resp.nack  <= 1'b0;
                step       <= 2'd0;
                state      <= ST_START;
            end
        end else if (state == ST_RESP) begin
            if (resp_ready) begin
                state <= ST_IDLE;
            end
        end else if (tick) begin
            step <= step + 2'd1;
            case (state)
                ST_START: begin
                    // sda falls while scl is high
                    case (step)
                        2'd0: begin
                            scl           <= 1'b1;
                            sda_drive_low <= 1'b0;
                        end
                        2'd1: sda_drive_low <= 1'b1;
                        default: begin
                            scl        <= 1'b0;
                            shreg      <= {cur.dev_addr, cur.read};
                            bit_cnt    <= 3'd0;
                            byte_cnt   <= 3'd0;
                            addr_phase <= 1'b1;
                            step       <= 2'd0;
                            state      <= ST_SHIFT;
                        end
                    endcase
                end
                ST_SHIFT: begin
                    case (step)
                        2'd0: sda_drive_low <= rx_data ? 1'b0 : ~shreg[7];
                        2'd1: begin
                            scl   <= 1'b1;
                            shreg <= {shreg[6:0], sda_in};
                        end
                        default: begin
                            scl     <= 1'b0;
                            step    <= 2'd0;
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7) begin
                                state <= ST_ACK;
                                if (rx_data) begin
                                    resp.rdata <= {resp.rdata[WBITS-9:0], shreg};
                                end
                            end
                        end
                    endcase
                end
                ST_ACK: begin
                    case (step)
                        // ack every read byte but the last
                        2'd0: sda_drive_low <= rx_data && !last_byte;
                        2'd1: begin
                            scl     <= 1'b1;
                            ack_bit <= sda_in;
                        end
                        default: begin
                            scl  <= 1'b0;
                            step <= 2'd0;
                            if (!rx_data && ack_bit) begin
                                resp.nack <= 1'b1;
                            end
                            if (!addr_phase) begin
                                byte_cnt <= byte_cnt + 3'd1;
                            end
                            if ((addr_phase && ack_bit) || (!addr_phase && last_byte)) begin
                                state <= ST_STOP;
                            end else begin
                                shreg      <= cur.wdata[WBITS-1 -: 8];
                                cur.wdata  <= cur.wdata << 8;
                                addr_phase <= 1'b0;
                                state      <= ST_SHIFT;
                            end
                        end
                    endcase
                end
                ST_STOP: begin
                    // sda rises while scl is high
                    case (step)
                        2'd0: sda_drive_low <= 1'b1;
                        2'd1: scl <= 1'b1;
                        2'd2: sda_drive_low <= 1'b0;
                        default: state <= ST_RESP;
                    endcase
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: source/i2c_pkg.sv
package i2c_pkg;

    // largest data byte count per transfer
    localparam int MAX_BYTES = 4;

    // one transfer as issued by a client
    typedef struct packed {
        logic [6:0]             dev_addr;
        logic                   read;
        logic [2:0]             nbytes;
        // first byte sent in the top byte
        logic [MAX_BYTES*8-1:0] wdata;
    } i2c_req_t;

    typedef struct packed {
        // last byte received lands in the low byte
        logic [MAX_BYTES*8-1:0] rdata;
        logic                   nack;
    } i2c_resp_t;

    typedef struct packed {
        logic [6:0] dev_addr;
        logic [7:0] reg_addr;
        logic [7:0] value;
    } cfg_write_t;

    typedef struct packed {
        logic [15:0] data;
        logic [7:0]  reg_addr;
        logic        nack;
    } sample_t;

    // arbiter client slots
    typedef enum logic {
        CLIENT_CFG  = 1'b0,
        CLIENT_POLL = 1'b1
    } client_idx_t;

endpackage

// File: source/i2c_subsystem.sv
`timescale 1ns/1ps

module i2c_subsystem #(
    parameter int         CLK_DIV       = 4,
    parameter int         POLL_INTERVAL = 4000,
    parameter logic [6:0] SENSOR_ADDR   = 7'h48,
    parameter logic [7:0] SENSOR_REG    = 8'h10
) (
    input  logic                clk,
    input  logic                rst,
    input  i2c_pkg::cfg_write_t cfg,
    input  logic                cfg_valid,
    output logic                cfg_ready,
    output logic                cfg_done_valid,
    output logic                cfg_done_nack,
    output i2c_pkg::sample_t    sample,
    output logic                sample_valid,
    output logic                scl,
    output logic                sda_drive_low,
    input  logic                sda_in
);

    i2c_pkg::i2c_req_t  cfg_req;
    logic               cfg_req_valid;
    logic               cfg_req_ready;
    i2c_pkg::i2c_resp_t cfg_resp;
    logic               cfg_resp_valid;
    logic               cfg_resp_ready;

    i2c_pkg::i2c_req_t  poll_req;
    logic               poll_req_valid;
    logic               poll_req_ready;
    i2c_pkg::i2c_resp_t poll_resp;
    logic               poll_resp_valid;
    logic               poll_resp_ready;

    i2c_pkg::i2c_req_t  eng_req;
    logic               eng_req_valid;
    logic               eng_req_ready;
    i2c_pkg::i2c_resp_t eng_resp;
    logic               eng_resp_valid;
    logic               eng_resp_ready;

    cfg_writer i_cfg_writer (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .cfg_valid  (cfg_valid),
        .cfg_ready  (cfg_ready),
        .done_valid (cfg_done_valid),
        .done_nack  (cfg_done_nack),
        .req        (cfg_req),
        .req_valid  (cfg_req_valid),
        .req_ready  (cfg_req_ready),
        .resp       (cfg_resp),
        .resp_valid (cfg_resp_valid),
        .resp_ready (cfg_resp_ready)
    );

    sensor_poller #(
        .POLL_INTERVAL (POLL_INTERVAL),
        .SENSOR_ADDR   (SENSOR_ADDR),
        .SENSOR_REG    (SENSOR_REG)
    ) i_sensor_poller (
        .clk          (clk),
        .rst          (rst),
        .sample       (sample),
        .sample_valid (sample_valid),
        .req          (poll_req),
        .req_valid    (poll_req_valid),
        .req_ready    (poll_req_ready),
        .resp         (poll_resp),
        .resp_valid   (poll_resp_valid),
        .resp_ready   (poll_resp_ready)
    );

    i2c_arbiter i_i2c_arbiter (
        .clk             (clk),
        .rst             (rst),
        .cfg_req         (cfg_req),
        .cfg_req_valid   (cfg_req_valid),
        .cfg_req_ready   (cfg_req_ready),
        .cfg_resp        (cfg_resp),
        .cfg_resp_valid  (cfg_resp_valid),
        .cfg_resp_ready  (cfg_resp_ready),
        .poll_req        (poll_req),
        .poll_req_valid  (poll_req_valid),
        .poll_req_ready  (poll_req_ready),
        .poll_resp       (poll_resp),
        .poll_resp_valid (poll_resp_valid),
        .poll_resp_ready (poll_resp_ready),
        .eng_req         (eng_req),
        .eng_req_valid   (eng_req_valid),
        .eng_req_ready   (eng_req_ready),
        .eng_resp        (eng_resp),
        .eng_resp_valid  (eng_resp_valid),
        .eng_resp_ready  (eng_resp_ready)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) i_i2c_bit_engine (
        .clk           (clk),
        .rst           (rst),
        .req           (eng_req),
        .req_valid     (eng_req_valid),
        .req_ready     (eng_req_ready),
        .resp          (eng_resp),
        .resp_valid    (eng_resp_valid),
        .resp_ready    (eng_resp_ready),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

endmodule

// File: source/sensor_poller.sv
`timescale 1ns/1ps

module sensor_poller #(
    parameter int         POLL_INTERVAL = 4000,
    parameter logic [6:0] SENSOR_ADDR   = 7'h48,
    parameter logic [7:0] SENSOR_REG    = 8'h10
) (
    input  logic               clk,
    input  logic               rst,
    output i2c_pkg::sample_t   sample,
    output logic               sample_valid,
    output i2c_pkg::i2c_req_t  req,
    output logic               req_valid,
    input  logic               req_ready,
    input  i2c_pkg::i2c_resp_t resp,
    input  logic               resp_valid,
    output logic               resp_ready
);

    localparam int PAD = (i2c_pkg::MAX_BYTES - 1) * 8;

    typedef enum logic [2:0] {
        SP_COUNT,
        SP_PTR_REQ,
        SP_PTR_WAIT,
        SP_RD_REQ,
        SP_RD_WAIT
    } state_t;

    state_t      state;
    logic [31:0] cnt;

    assign req_valid  = (state == SP_PTR_REQ) || (state == SP_RD_REQ);
    assign resp_ready = (state == SP_PTR_WAIT) || (state == SP_RD_WAIT);

    // pointer write is one byte, the read is two
    assign req.dev_addr = SENSOR_ADDR;
    assign req.read     = (state == SP_RD_REQ);
    assign req.nbytes   = (state == SP_RD_REQ) ? 3'd2 : 3'd1;
    assign req.wdata    = {SENSOR_REG, {PAD{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= SP_COUNT;
            cnt          <= 32'(POLL_INTERVAL);
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            case (state)
                SP_COUNT: begin
                    if (cnt == '0) begin
                        state <= SP_PTR_REQ;
                    end else begin
                        cnt <= cnt - 32'd1;
                    end
                end
                SP_PTR_REQ: begin
                    if (req_ready) begin
                        state <= SP_PTR_WAIT;
                    end
                end
                SP_PTR_WAIT: begin
                    if (resp_valid) begin
                        if (resp.nack) begin
                            // no read after a refused pointer write
                            sample_valid    <= 1'b1;
                            sample.data     <= resp.rdata[15:0];
                            sample.reg_addr <= SENSOR_REG;
                            sample.nack     <= 1'b1;
                            cnt             <= 32'(POLL_INTERVAL);
                            state           <= SP_COUNT;
                        end else begin
                            state <= SP_RD_REQ;
                        end
                    end
                end
                SP_RD_REQ: begin
                    if (req_ready) begin
                        state <= SP_RD_WAIT;
                    end
                end
                default: begin
                    if (resp_valid) begin
                        // first byte read ends up in the high half
                        sample_valid    <= 1'b1;
                        sample.data     <= resp.rdata[15:0];
                        sample.reg_addr <= SENSOR_REG;
                        sample.nack     <= resp.nack;
                        cnt             <= 32'(POLL_INTERVAL);
                        state           <= SP_COUNT;
                    end
                end
            endcase
        end
    end

endmodule

// File: vlog.f
source/i2c_pkg.sv
source/i2c_bit_engine.sv
source/i2c_arbiter.sv
source/cfg_writer.sv
source/sensor_poller.sv
source/i2c_subsystem.sv
dv/i2c_target_model.sv
dv/i2c_checker.sv
dv/tb_i2c_subsystem.sv
